// File: hdl/mem_link_config.svh
/*
  Widths, coordinates and endpoint sizing for the memory link.
  Included by the package and by every module that needs a width or a constant.
*/
`ifndef MEM_LINK_CONFIG_SVH
`define MEM_LINK_CONFIG_SVH

`define MEM_LINK_FLIT_W      32
`define MEM_LINK_CORD_W      4
`define MEM_LINK_LEN_W       4
`define MEM_LINK_CID_W       2
`define MEM_LINK_DATA_W      64
`define MEM_LINK_ADDR_W      16
`define MEM_LINK_TAG_W       4
`define MEM_LINK_OP_W        2
`define MEM_LINK_HDR_W       (`MEM_LINK_OP_W + `MEM_LINK_ADDR_W + `MEM_LINK_TAG_W)

`define MEM_LINK_MEM_CORD    4'd5 // endpoint position on the link
`define MEM_LINK_HOME_CORD   4'd0 // responses go back here
`define MEM_LINK_BANK_WORDS  16

// one bit per opcode, set where the message carries a data block
`define MEM_LINK_CMD_MASK    4'b0010
`define MEM_LINK_RESP_MASK   4'b0001

`endif

// File: hdl/mem_link_pkg.sv
/*
  Link and memory-message types, plus helpers that pick fields out of a head flit.
*/
`default_nettype none

`include "mem_link_config.svh"

package mem_link_pkg;

  typedef logic [`MEM_LINK_FLIT_W-1:0] flit_t;
  typedef logic [`MEM_LINK_CORD_W-1:0] cord_t;
  typedef logic [`MEM_LINK_LEN_W-1:0]  len_t;   // flits after the head
  typedef logic [`MEM_LINK_CID_W-1:0]  cid_t;
  typedef logic [`MEM_LINK_ADDR_W-1:0] mem_addr_t;
  typedef logic [`MEM_LINK_TAG_W-1:0]  mem_tag_t;
  typedef logic [`MEM_LINK_DATA_W-1:0] mem_data_t;

  typedef enum logic [`MEM_LINK_OP_W-1:0] {
    e_mem_rd   = 2'd0,
    e_mem_wr   = 2'd1,
    e_mem_rsv2 = 2'd2,
    e_mem_rsv3 = 2'd3
  } mem_opcode_e;

  // {opcode, addr, tag}
  typedef logic [`MEM_LINK_HDR_W-1:0] mem_header_t;

  typedef enum logic [1:0] {e_ser_idle, e_ser_head, e_ser_lo, e_ser_hi} ser_state_e;
  typedef enum logic {e_ep_check, e_ep_resp} ep_state_e;

  // ##########################################################################
  // head flit is {header, cid, len, cord} from msb to lsb

  function automatic cord_t flit_cord(flit_t f);
    return f[`MEM_LINK_CORD_W-1:0];
  endfunction

  function automatic len_t flit_len(flit_t f);
    return f[`MEM_LINK_CORD_W +: `MEM_LINK_LEN_W];
  endfunction

  function automatic cid_t flit_cid(flit_t f);
    return f[`MEM_LINK_CORD_W + `MEM_LINK_LEN_W +: `MEM_LINK_CID_W];
  endfunction

  function automatic mem_header_t flit_hdr(flit_t f);
    return f[`MEM_LINK_FLIT_W-1 -: `MEM_LINK_HDR_W];
  endfunction

  function automatic mem_opcode_e hdr_opcode(mem_header_t h);
    return mem_opcode_e'(h[`MEM_LINK_HDR_W-1 -: `MEM_LINK_OP_W]);
  endfunction

  function automatic mem_addr_t hdr_addr(mem_header_t h);
    return h[`MEM_LINK_TAG_W +: `MEM_LINK_ADDR_W];
  endfunction

endpackage

`default_nettype wire

// File: hdl/mem_wh_header_encode.sv
/*
  Builds the wormhole head flit from a memory header and the routing target.
  data_mask_p marks the opcodes whose message carries a data block.
*/
`timescale 1ns/100ps
`default_nettype none

`include "mem_link_config.svh"

module mem_wh_header_encode
  import mem_link_pkg::*;
#(
  parameter logic [3:0] data_mask_p = `MEM_LINK_CMD_MASK
) (
  input  mem_header_t header_i,
  input  cord_t       dst_cord_i,
  input  cid_t        dst_cid_i,
  output flit_t       flit_o
);

  localparam int unsigned data_flits_lp = `MEM_LINK_DATA_W / `MEM_LINK_FLIT_W;

  mem_opcode_e opcode;
  len_t        len;

  assign opcode = hdr_opcode(header_i);

  always_comb begin
    if (data_mask_p[opcode]) begin
      len = len_t'(data_flits_lp); // block follows the head
    end else begin
      len = '0;
    end
  end

  assign flit_o = {header_i, dst_cid_i, len, dst_cord_i};

endmodule

`default_nettype wire

// File: hdl/wh_flit_serializer.sv
/*
  Sends a registered packet as head flit plus optional data halves on a
  valid/ready_and link. Takes a new packet only while idle.
*/
`timescale 1ns/100ps
`default_nettype none

`include "mem_link_config.svh"

module wh_flit_serializer
  import mem_link_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,

  input  flit_t     first_flit_i,
  input  mem_data_t data_i,
  input  logic      v_i,
  output logic      ready_o,

  output flit_t     link_data_o,
  output logic      link_v_o,
  input  logic      link_ready_and_i
);

  ser_state_e state_r;
  flit_t      first_r;
  mem_data_t  data_r;
  logic       accept;
  logic       link_go;

  assign ready_o = (state_r == e_ser_idle);
  assign accept  = v_i & ready_o;
  assign link_go = link_v_o & link_ready_and_i;

  // packet payload, held through stalls
  always_ff @(posedge clk_i) begin
    if (accept) begin
      first_r <= first_flit_i;
      data_r  <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= e_ser_idle;
    end else begin
      case (state_r)
        e_ser_idle: if (accept) state_r <= e_ser_head;
        e_ser_head: begin
          if (link_go) begin
            state_r <= (flit_len(first_r) == '0) ? e_ser_idle : e_ser_lo;
          end
        end
        e_ser_lo:   if (link_go) state_r <= e_ser_hi;
        e_ser_hi:   if (link_go) state_r <= e_ser_idle;
        default:    state_r <= e_ser_idle;
      endcase
    end
  end

  assign link_v_o = (state_r != e_ser_idle);

  always_comb begin
    case (state_r)
      e_ser_lo: link_data_o = data_r[`MEM_LINK_FLIT_W-1:0];
      e_ser_hi: link_data_o = data_r[`MEM_LINK_DATA_W-1 -: `MEM_LINK_FLIT_W];
      default:  link_data_o = first_r; // head, also parked value when idle
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/wh_flit_deserializer.sv
/*
  Collects a head flit and its data flits from a valid/ready_and link and
  presents the packet until the consumer takes it with yumi.
*/
`timescale 1ns/100ps
`default_nettype none

`include "mem_link_config.svh"

module wh_flit_deserializer
  import mem_link_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,

  input  flit_t     link_data_i,
  input  logic      link_v_i,
  output logic      link_ready_and_o,

  output flit_t     first_flit_o,
  output mem_data_t data_o,
  output logic      v_o,
  input  logic      yumi_i
);

  flit_t     first_r;
  mem_data_t data_r;
  len_t      cnt_r;   // data flits still to come
  logic      busy_r;  // head taken, body pending
  logic      v_r;
  logic      take;

  assign link_ready_and_o = ~v_r;
  assign take             = link_v_i & link_ready_and_o;

  always_ff @(posedge clk_i) begin
    if (take) begin
      if (!busy_r) begin
        first_r <= link_data_i;
        data_r  <= '0; // header-only packets read back as zero data
      end else begin
        data_r <= {link_data_i, data_r[`MEM_LINK_DATA_W-1:`MEM_LINK_FLIT_W]};
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_r <= 1'b0;
      cnt_r  <= '0;
      v_r    <= 1'b0;
    end else begin
      if (take) begin
        if (!busy_r) begin
          if (flit_len(link_data_i) == '0) begin
            v_r <= 1'b1;
          end else begin
            busy_r <= 1'b1;
            cnt_r  <= flit_len(link_data_i);
          end
        end else begin
          cnt_r <= cnt_r - 1'b1;
          if (cnt_r == len_t'(1)) begin
            busy_r <= 1'b0;
            v_r    <= 1'b1;  // last flit in
          end
        end
      end else if (yumi_i) begin
        v_r <= 1'b0;
      end
    end
  end

  assign first_flit_o = first_r;
  assign data_o       = data_r;
  assign v_o          = v_r;

endmodule

`default_nettype wire

// File: hdl/mem_link_send.sv
/*
  Host-side link adapter. Encodes memory commands into flits for the command
  link and turns response packets back into memory headers and data.
*/
`timescale 1ns/100ps
`default_nettype none

`include "mem_link_config.svh"

module mem_link_send
  import mem_link_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  cord_t       dst_cord_i,
  input  cid_t        dst_cid_i,

  input  mem_header_t mem_cmd_header_i,
  input  mem_data_t   mem_cmd_data_i,
  input  logic        mem_cmd_v_i,
  output logic        mem_cmd_ready_and_o,

  output mem_header_t mem_resp_header_o,
  output mem_data_t   mem_resp_data_o,
  output logic        mem_resp_v_o,
  input  logic        mem_resp_yumi_i,

  output flit_t       cmd_link_data_o,
  output logic        cmd_link_v_o,
  input  logic        cmd_link_ready_and_i,

  input  flit_t       resp_link_data_i,
  input  logic        resp_link_v_i,
  output logic        resp_link_ready_and_o
);

  flit_t cmd_head;
  flit_t resp_head;

  mem_wh_header_encode #(
    .data_mask_p(`MEM_LINK_CMD_MASK)
  ) i_cmd_encode (
    .header_i  (mem_cmd_header_i),
    .dst_cord_i(dst_cord_i),
    .dst_cid_i (dst_cid_i),
    .flit_o    (cmd_head)
  );

  wh_flit_serializer i_cmd_ser (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .first_flit_i    (cmd_head),
    .data_i          (mem_cmd_data_i),
    .v_i             (mem_cmd_v_i),
    .ready_o         (mem_cmd_ready_and_o),
    .link_data_o     (cmd_link_data_o),
    .link_v_o        (cmd_link_v_o),
    .link_ready_and_i(cmd_link_ready_and_i)
  );

  wh_flit_deserializer i_resp_des (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .link_data_i     (resp_link_data_i),
    .link_v_i        (resp_link_v_i),
    .link_ready_and_o(resp_link_ready_and_o),
    .first_flit_o    (resp_head),
    .data_o          (mem_resp_data_o),
    .v_o             (mem_resp_v_o),
    .yumi_i          (mem_resp_yumi_i)
  );

  assign mem_resp_header_o = flit_hdr(resp_head); // routing fields dropped

endmodule

`default_nettype wire

// File: hdl/mem_link_endpoint.sv
/*
  Memory endpoint on the link. Receives command packets, serves them from two
  banks chosen by core id and sends responses toward the home coordinate.
*/
`timescale 1ns/100ps
`default_nettype none

`include "mem_link_config.svh"

module mem_link_endpoint
  import mem_link_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,

  input  flit_t cmd_link_data_i,
  input  logic  cmd_link_v_i,
  output logic  cmd_link_ready_and_o,

  output flit_t resp_link_data_o,
  output logic  resp_link_v_o,
  input  logic  resp_link_ready_and_i
);

  localparam int unsigned word_w_lp = $clog2(`MEM_LINK_BANK_WORDS);

  flit_t       cmd_head;
  mem_data_t   cmd_data;
  logic        cmd_v;
  logic        cmd_yumi;
  mem_header_t cmd_hdr;
  cid_t        cmd_cid;
  mem_opcode_e cmd_op;
  mem_addr_t   cmd_addr;
  logic        cord_hit;
  logic        serve;

  ep_state_e   state_r;
  mem_data_t   resp_data_r;
  flit_t       resp_head;
  logic        resp_v;
  logic        resp_ready;

  mem_data_t   bank_mem [2][`MEM_LINK_BANK_WORDS];

  wh_flit_deserializer i_cmd_des (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .link_data_i     (cmd_link_data_i),
    .link_v_i        (cmd_link_v_i),
    .link_ready_and_o(cmd_link_ready_and_o),
    .first_flit_o    (cmd_head),
    .data_o          (cmd_data),
    .v_o             (cmd_v),
    .yumi_i          (cmd_yumi)
  );

  assign cmd_hdr  = flit_hdr(cmd_head);
  assign cmd_cid  = flit_cid(cmd_head);
  assign cmd_op   = hdr_opcode(cmd_hdr);
  assign cmd_addr = hdr_addr(cmd_hdr);
  assign cord_hit = (flit_cord(cmd_head) == `MEM_LINK_MEM_CORD);
  assign serve    = (state_r == e_ep_check) & cmd_v & cord_hit;

  // ##########################################################################
  // control

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= e_ep_check;
    end else begin
      case (state_r)
        e_ep_check: if (serve) state_r <= e_ep_resp;
        e_ep_resp:  if (resp_ready) state_r <= e_ep_check; // response taken
        default:    state_r <= e_ep_check;
      endcase
    end
  end

  // free the command once answered, or at once when misrouted
  assign cmd_yumi = ((state_r == e_ep_check) & cmd_v & ~cord_hit)
                  | ((state_r == e_ep_resp) & resp_ready);

  // ##########################################################################
  // storage, bank from cid bit 0

  always_ff @(posedge clk_i) begin
    if (serve) begin
      if (cmd_op == e_mem_wr) begin
        bank_mem[cmd_cid[0]][cmd_addr[word_w_lp-1:0]] <= cmd_data;
      end
      if (cmd_op == e_mem_rd) begin
        resp_data_r <= bank_mem[cmd_cid[0]][cmd_addr[word_w_lp-1:0]];
      end else begin
        resp_data_r <= '0; // acks carry no data
      end
    end
  end

  // ##########################################################################
  // response

  mem_wh_header_encode #(
    .data_mask_p(`MEM_LINK_RESP_MASK)
  ) i_resp_encode (
    .header_i  (cmd_hdr),   // opcode and tag echoed
    .dst_cord_i(`MEM_LINK_HOME_CORD),
    .dst_cid_i (cmd_cid),
    .flit_o    (resp_head)
  );

  assign resp_v = (state_r == e_ep_resp);

  wh_flit_serializer i_resp_ser (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .first_flit_i    (resp_head),
    .data_i          (resp_data_r),
    .v_i             (resp_v),
    .ready_o         (resp_ready),
    .link_data_o     (resp_link_data_o),
    .link_v_o        (resp_link_v_o),
    .link_ready_and_i(resp_link_ready_and_i)
  );

endmodule

`default_nettype wire

// File: hdl/mem_link_top.sv
/*
  Sender and memory endpoint joined by the command and response links.
*/
`timescale 1ns/100ps
`default_nettype none

`include "mem_link_config.svh"

module mem_link_top
  import mem_link_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  cord_t       dst_cord_i,
  input  cid_t        dst_cid_i,

  input  mem_header_t mem_cmd_header_i,
  input  mem_data_t   mem_cmd_data_i,
  input  logic        mem_cmd_v_i,
  output logic        mem_cmd_ready_and_o,

  output mem_header_t mem_resp_header_o,
  output mem_data_t   mem_resp_data_o,
  output logic        mem_resp_v_o,
  input  logic        mem_resp_yumi_i
);

  flit_t cmd_link_data;
  logic  cmd_link_v;
  logic  cmd_link_ready_and;
  flit_t resp_link_data;
  logic  resp_link_v;
  logic  resp_link_ready_and;

  mem_link_send i_send (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .dst_cord_i           (dst_cord_i),
    .dst_cid_i            (dst_cid_i),
    .mem_cmd_header_i     (mem_cmd_header_i),
    .mem_cmd_data_i       (mem_cmd_data_i),
    .mem_cmd_v_i          (mem_cmd_v_i),
    .mem_cmd_ready_and_o  (mem_cmd_ready_and_o),
    .mem_resp_header_o    (mem_resp_header_o),
    .mem_resp_data_o      (mem_resp_data_o),
    .mem_resp_v_o         (mem_resp_v_o),
    .mem_resp_yumi_i      (mem_resp_yumi_i),
    .cmd_link_data_o      (cmd_link_data),
    .cmd_link_v_o         (cmd_link_v),
    .cmd_link_ready_and_i (cmd_link_ready_and),
    .resp_link_data_i     (resp_link_data),
    .resp_link_v_i        (resp_link_v),
    .resp_link_ready_and_o(resp_link_ready_and)
  );

  mem_link_endpoint i_mem (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .cmd_link_data_i      (cmd_link_data),
    .cmd_link_v_i         (cmd_link_v),
    .cmd_link_ready_and_o (cmd_link_ready_and),
    .resp_link_data_o     (resp_link_data),
    .resp_link_v_o        (resp_link_v),
    .resp_link_ready_and_i(resp_link_ready_and)
  );

endmodule

`default_nettype wire

// File: verif/mem_link_props.sv
/*
  Handshake properties for the memory link, attached to mem_link_top
  through the bind at the end of this file.
*/
`timescale 1ns/100ps
`default_nettype none

module mem_link_props
  import mem_link_pkg::*;
(
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        mem_resp_v_i,
  input mem_header_t mem_resp_header_i,
  input logic        mem_resp_yumi_i,
  input logic        cmd_link_v_i,
  input flit_t       cmd_link_data_i,
  input logic        cmd_link_ready_and_i,
  input logic        resp_link_v_i
);

  a_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_resp_v_i && !mem_resp_yumi_i |=> mem_resp_v_i && $stable(mem_resp_header_i)
  ) else $error("response valid or header changed before yumi");

  a_cmd_link_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cmd_link_v_i && !cmd_link_ready_and_i |=> cmd_link_v_i && $stable(cmd_link_data_i)
  ) else $error("command flit dropped or changed while stalled");

  a_yumi_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_resp_yumi_i |-> mem_resp_v_i
  ) else $error("yumi raised without a valid response");

  // first cycle out of reset
  a_reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !mem_resp_v_i && !cmd_link_v_i && !resp_link_v_i
  ) else $error("valid output high right after reset");

endmodule

bind mem_link_top mem_link_props i_props (
  .clk_i               (clk_i),
  .rst_n_i             (rst_n_i),
  .mem_resp_v_i        (mem_resp_v_o),
  .mem_resp_header_i   (mem_resp_header_o),
  .mem_resp_yumi_i     (mem_resp_yumi_i),
  .cmd_link_v_i        (cmd_link_v),
  .cmd_link_data_i     (cmd_link_data),
  .cmd_link_ready_and_i(cmd_link_ready_and),
  .resp_link_v_i       (resp_link_v)
);

`default_nettype wire

// File: verif/mem_link_tb.sv
/*
  Testbench for mem_link_top. Directed and random memory commands go in and
  responses are checked in command order against a two-bank model.
*/
`timescale 1ns/100ps
`default_nettype none

`include "mem_link_config.svh"

module mem_link_tb
  import mem_link_pkg::*;
();

  logic        clk_i;
  logic        rst_n_i;
  cord_t       dst_cord_i;
  cid_t        dst_cid_i;
  mem_header_t mem_cmd_header_i;
  mem_data_t   mem_cmd_data_i;
  logic        mem_cmd_v_i;
  logic        mem_cmd_ready_and_o;
  mem_header_t mem_resp_header_o;
  mem_data_t   mem_resp_data_o;
  logic        mem_resp_v_o;
  logic        mem_resp_yumi_i;

  mem_data_t   model [2][`MEM_LINK_BANK_WORDS];
  mem_header_t exp_hdr_q [$];
  mem_data_t   exp_data_q [$];
  logic [31:0] stim_lfsr;
  logic [31:0] yumi_lfsr;
  logic        stall_en;   // random yumi back-pressure
  int          errors;
  int          timeouts;
  int          checks;

  mem_link_top i_dut (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .dst_cord_i         (dst_cord_i),
    .dst_cid_i          (dst_cid_i),
    .mem_cmd_header_i   (mem_cmd_header_i),
    .mem_cmd_data_i     (mem_cmd_data_i),
    .mem_cmd_v_i        (mem_cmd_v_i),
    .mem_cmd_ready_and_o(mem_cmd_ready_and_o),
    .mem_resp_header_o  (mem_resp_header_o),
    .mem_resp_data_o    (mem_resp_data_o),
    .mem_resp_v_o       (mem_resp_v_o),
    .mem_resp_yumi_i    (mem_resp_yumi_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [63:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      v = {v[62:0], stim_lfsr[0]};
    end
  endtask

  // differs per bank and per address
  function automatic mem_data_t fill_word(cid_t cid, mem_addr_t addr);
    return {cid, 14'h0, addr, 16'hf111, ~addr};
  endfunction

  // ##########################################################################
  // reference model fed from handshakes seen at the clock edge

  task automatic record_cmd();
    mem_opcode_e op;
    logic [3:0]  idx;
    logic        bank;
    op   = mem_opcode_e'(mem_cmd_header_i[21:20]);
    idx  = mem_cmd_header_i[7:4];   // addr bits 3:0
    bank = dst_cid_i[0];
    exp_hdr_q.push_back(mem_cmd_header_i);
    if (op == e_mem_rd) begin
      exp_data_q.push_back(model[bank][idx]);
    end else begin
      exp_data_q.push_back('0);
    end
    if (op == e_mem_wr) begin
      model[bank][idx] = mem_cmd_data_i;
    end
  endtask

  task automatic check_resp();
    mem_header_t eh;
    mem_data_t   ed;
    if (exp_hdr_q.size() == 0) begin
      errors++;
      $display("%0t: response taken with no command outstanding", $time);
    end else begin
      eh = exp_hdr_q.pop_front();
      ed = exp_data_q.pop_front();
      checks++;
      assert (mem_resp_header_o === eh) else begin
        errors++;
        $display("FAILED %0t mem_resp_header_o expected %h actual %h",
                 $time, eh, mem_resp_header_o);
      end
      assert (mem_resp_data_o === ed) else begin
        errors++;
        $display("FAILED %0t mem_resp_data_o expected %h actual %h",
                 $time, ed, mem_resp_data_o);
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_n_i && mem_cmd_v_i && mem_cmd_ready_and_o
        && dst_cord_i == `MEM_LINK_MEM_CORD) begin
      record_cmd();
    end
    if (rst_n_i && mem_resp_v_o && mem_resp_yumi_i) begin
      check_resp();
    end
  end

  // yumi only while valid and one take in four when stalling
  always @(negedge clk_i) begin : yumi_drive
    logic [1:0] b;
    yumi_lfsr = lfsr_next(yumi_lfsr);
    b[0] = yumi_lfsr[0];
    yumi_lfsr = lfsr_next(yumi_lfsr);
    b[1] = yumi_lfsr[0];
    mem_resp_yumi_i = rst_n_i && mem_resp_v_o && (!stall_en || b == 2'b00);
  end

  // ##########################################################################
  // stimulus

  task automatic send_cmd(input mem_opcode_e op, input mem_addr_t addr,
                          input mem_tag_t tag, input mem_data_t data,
                          input cord_t cord, input cid_t cid);
    int n;
    @(negedge clk_i);
    mem_cmd_header_i = {op, addr, tag};
    mem_cmd_data_i   = data;
    dst_cord_i       = cord;
    dst_cid_i        = cid;
    mem_cmd_v_i      = 1'b1;
    n = 0;
    while (!mem_cmd_ready_and_o && n < 500) begin
      @(negedge clk_i);
      n++;
    end
    if (!mem_cmd_ready_and_o) begin
      timeouts++;
      $display("%0t: timeout, command was never accepted", $time);
    end
    @(negedge clk_i);   // handshake edge has passed
    mem_cmd_v_i = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_hdr_q.size() != 0 || mem_resp_v_o) && n < 2000) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_hdr_q.size() != 0 || mem_resp_v_o) begin
      timeouts++;
      $display("%0t: timeout, %0d responses still missing", $time, exp_hdr_q.size());
    end
  endtask

  task automatic expect_quiet(input int cycles);
    int n;
    for (n = 0; n < cycles; n++) begin
      @(negedge clk_i);
      assert (!mem_resp_v_o) else begin
        errors++;
        $display("FAILED %0t mem_resp_v_o expected 0 actual %b", $time, mem_resp_v_o);
      end
    end
  endtask

  initial begin
    int          c;
    int          a;
    int          i;
    logic [63:0] r;
    mem_opcode_e op;
    mem_addr_t   addr;
    mem_tag_t    tag;
    cid_t        cid;
    rst_n_i          = 1'b0;
    dst_cord_i       = `MEM_LINK_MEM_CORD;
    dst_cid_i        = '0;
    mem_cmd_header_i = '0;
    mem_cmd_data_i   = '0;
    mem_cmd_v_i      = 1'b0;
    mem_resp_yumi_i  = 1'b0;
    stall_en         = 1'b0;
    stim_lfsr        = 32'h9d94;
    yumi_lfsr        = 32'h9d94;
    errors           = 0;
    timeouts         = 0;
    checks           = 0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    for (c = 0; c < 2; c++) begin   // preload both banks
      for (a = 0; a < `MEM_LINK_BANK_WORDS; a++) begin
        send_cmd(e_mem_wr, mem_addr_t'(a), 4'h0, fill_word(cid_t'(c), mem_addr_t'(a)),
                 `MEM_LINK_MEM_CORD, cid_t'(c));
      end
    end
    wait_drain();

    send_cmd(e_mem_wr, 16'h0003, 4'h1, 64'h0123_4567_89ab_cdef, `MEM_LINK_MEM_CORD, 2'd0);
    send_cmd(e_mem_rd, 16'h0003, 4'h2, 64'h0, `MEM_LINK_MEM_CORD, 2'd0);
    wait_drain();

    send_cmd(e_mem_rsv2, 16'h0003, 4'h3, 64'hdead_beef_dead_beef, `MEM_LINK_MEM_CORD, 2'd0);
    send_cmd(e_mem_rsv3, 16'h0003, 4'h4, 64'hbad0_bad0_bad0_bad0, `MEM_LINK_MEM_CORD, 2'd0);
    send_cmd(e_mem_rd, 16'h0003, 4'h5, 64'h0, `MEM_LINK_MEM_CORD, 2'd0);
    wait_drain();

    send_cmd(e_mem_wr, 16'h0007, 4'h6, 64'haaaa_0000_aaaa_0000, `MEM_LINK_MEM_CORD, 2'd0);
    send_cmd(e_mem_wr, 16'h0007, 4'h7, 64'h5555_1111_5555_1111, `MEM_LINK_MEM_CORD, 2'd1);
    send_cmd(e_mem_rd, 16'h0007, 4'h8, 64'h0, `MEM_LINK_MEM_CORD, 2'd0);
    send_cmd(e_mem_rd, 16'h0007, 4'h9, 64'h0, `MEM_LINK_MEM_CORD, 2'd1);
    wait_drain();

    send_cmd(e_mem_wr, 16'h0007, 4'ha, 64'hffff_ffff_ffff_ffff, 4'd3, 2'd0);
    expect_quiet(200);
    send_cmd(e_mem_rd, 16'h0007, 4'hb, 64'h0, `MEM_LINK_MEM_CORD, 2'd0);
    wait_drain();

    stall_en = 1'b1;
    for (i = 0; i < 60; i++) begin
      rand_bits(2, r);
      op = mem_opcode_e'(r[1:0]);
      rand_bits(16, r);
      addr = r[15:0];
      rand_bits(4, r);
      tag = r[3:0];
      rand_bits(2, r);
      cid = r[1:0];
      rand_bits(64, r);
      send_cmd(op, addr, tag, r, `MEM_LINK_MEM_CORD, cid);
    end
    wait_drain();
    stall_en = 1'b0;

    $display("errors: %0d  timeouts: %0d  responses checked: %0d", errors, timeouts, checks);
    if (errors == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hdl
hdl/mem_link_pkg.sv
hdl/mem_wh_header_encode.sv
hdl/wh_flit_serializer.sv
hdl/wh_flit_deserializer.sv
hdl/mem_link_send.sv
hdl/mem_link_endpoint.sv
hdl/mem_link_top.sv
verif/mem_link_props.sv
verif/mem_link_tb.sv
